//--- compile.f
+incdir+logic
logic/pipe_pkg.sv
logic/mem_pkg.sv
logic/stage_if.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/data_sram.sv
logic/mem_pipe_top.sv
tb/tb_clock_gen.sv
tb/mem_pipe_tb.sv

//--- Bender.yml
package:
  name: mem_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/pipe_pkg.sv
      - logic/mem_pkg.sv
      - logic/stage_if.sv
      - logic/ex_stage.sv
      - logic/mem_stage.sv
      - logic/wb_stage.sv
      - logic/data_sram.sv
      - logic/mem_pipe_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_clock_gen.sv
      - tb/mem_pipe_tb.sv

//--- tb/mem_pipe_tb.sv
`include "pipe_config.svh"

module mem_pipe_tb;
    localparam int N_FILL      = 16;
    localparam int N_DIRECT    = 21;
    localparam int N_RAND      = 150;
    localparam int N_EXC       = 13;
    localparam int CYCLE_LIMIT = 20 * (N_FILL + N_DIRECT + 2 * N_RAND + N_EXC) + 100;

    // expected outcome of one accepted op
    typedef struct packed {
        logic                     retires;
        logic                     is_exc;
        pipe_pkg::exc_code_t      code;
        logic [31:0]              pc;
        logic [31:0]              vaddr;
        pipe_pkg::rf_wr_t         rf;
        logic                     st_en;
        logic [`PIPE_SRAM_AW-1:0] st_idx;
        logic [31:0]              st_word;
    } exp_t;

    logic                clk;
    logic                resetn;
    logic                in_valid;
    logic                in_allowin;
    mem_pkg::mem_op_t    in_op;
    logic [31:0]         in_pc;
    logic [31:0]         in_base;
    logic [31:0]         in_offset;
    logic [31:0]         in_store_data;
    logic [4:0]          in_rd;
    logic                retire_ready;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [31:0]         rf_wdata;
    logic [31:0]         retire_pc;
    logic                exc_valid;
    pipe_pkg::exc_code_t exc_code;
    logic [31:0]         exc_pc;
    logic [31:0]         exc_vaddr;

    integer      seed = 32'h68d9;
    logic [31:0] shadow [`PIPE_SRAM_DEPTH];
    exp_t        exp_q [$];
    int          exc_issued = 0;
    int          exc_retired = 0;
    int          cycles = 0;
    bit          rr_random = 1'b0;
    logic [31:0] next_pc = 32'h1c00_0000;

    tb_clock_gen #(.PERIOD(20)) clock_i (.clk(clk));

    mem_pipe_top dut_i (.*);

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a ^ 8'ha6, ~a, a + 8'h31, a};
    endfunction

    function automatic exp_t ref_result(input mem_pkg::mem_op_t op, input logic [31:0] pc,
            input logic [31:0] base, input logic [31:0] offset, input logic [31:0] sdata,
            input logic [4:0] rd);
        exp_t        e;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] lane;
        logic        bad;
        addr = base + offset;
        word = shadow[addr[`PIPE_SRAM_AW+1:2]];
        lane = word >> (8 * addr[1:0]);
        e = '0;
        e.retires  = 1'b1;
        e.code     = pipe_pkg::EXC_NONE;
        e.pc       = pc;
        e.vaddr    = addr;
        e.rf.we    = 1'b1;
        e.rf.waddr = rd;
        e.st_idx   = addr[`PIPE_SRAM_AW+1:2];
        e.st_word  = word;
        case (op)
            mem_pkg::OP_LD_W, mem_pkg::OP_ST_W: bad = addr[1:0] != 2'b00;
            mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU, mem_pkg::OP_ST_H: bad = addr[0];
            default: bad = 1'b0;
        endcase
        if (bad) begin
            e.is_exc = 1'b1;
            e.code   = pipe_pkg::EXC_ALE;
            e.rf.we  = 1'b0;
            return e;
        end
        case (op)
            mem_pkg::OP_LD_W:  e.rf.wdata = word;
            mem_pkg::OP_LD_H:  e.rf.wdata = {{16{lane[15]}}, lane[15:0]};
            mem_pkg::OP_LD_HU: e.rf.wdata = {16'h0000, lane[15:0]};
            mem_pkg::OP_LD_B:  e.rf.wdata = {{24{lane[7]}}, lane[7:0]};
            mem_pkg::OP_LD_BU: e.rf.wdata = {24'h000000, lane[7:0]};
            mem_pkg::OP_ST_W:  e.st_word = sdata;
            mem_pkg::OP_ST_H:  e.st_word[16 * addr[1] +: 16] = sdata[15:0];
            mem_pkg::OP_ST_B:  e.st_word[8 * addr[1:0] +: 8] = sdata[7:0];
            default:           e.rf.wdata = addr;
        endcase
        // stores update memory and leave no retire report
        if (op inside {mem_pkg::OP_ST_W, mem_pkg::OP_ST_H, mem_pkg::OP_ST_B}) begin
            e.retires = 1'b0;
            e.st_en   = 1'b1;
        end
        return e;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_rf(input pipe_pkg::rf_wr_t got, input pipe_pkg::rf_wr_t exp);
        if (got !== exp)
            report_failure($sformatf(
                "FAILED rf_we/rf_waddr/rf_wdata: got %h/%h/%h expected %h/%h/%h",
                got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata));
    endtask

    task automatic check_exc(input pipe_pkg::exc_code_t got_code,
            input pipe_pkg::exc_code_t exp_code,
            input logic [31:0] got_pc, input logic [31:0] exp_pc,
            input logic [31:0] got_vaddr, input logic [31:0] exp_vaddr);
        if (got_code !== exp_code)
            report_failure($sformatf("FAILED exc_code: got %h expected %h", got_code, exp_code));
        if (got_pc !== exp_pc)
            report_failure($sformatf("FAILED exc_pc: got %h expected %h", got_pc, exp_pc));
        if (got_vaddr !== exp_vaddr)
            report_failure($sformatf("FAILED exc_vaddr: got %h expected %h",
                got_vaddr, exp_vaddr));
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("FAILED retire_pc: got %h expected %h", got, exp));
    endtask

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        r = $random(seed);
        retire_ready = rr_random ? r[1:0] != 2'b00 : 1'b1;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic issue_op(input mem_pkg::mem_op_t op, input logic [31:0] base,
            input logic [31:0] offset, input logic [31:0] sdata, input logic [4:0] rd);
        exp_t e;
        in_valid      = 1'b1;
        in_op         = op;
        in_pc         = next_pc;
        in_base       = base;
        in_offset     = offset;
        in_store_data = sdata;
        in_rd         = rd;
        @(negedge clk);
        while (!in_allowin) begin
            next_cycle();
            @(negedge clk);
        end
        // taken at the coming edge, dropped while an exception is unreported
        if (exc_issued == exc_retired) begin
            e = ref_result(op, next_pc, base, offset, sdata, rd);
            if (e.is_exc)
                exc_issued++;
            if (e.st_en)
                shadow[e.st_idx] = e.st_word;
            if (e.retires)
                exp_q.push_back(e);
        end
        next_pc = next_pc + 32'd4;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic issue_random();
        mem_pkg::mem_op_t op;
        logic [31:0]      r;
        logic [31:0]      addr;
        logic [31:0]      base;
        logic [31:0]      sdata;
        r     = $random(seed);
        base  = $random(seed);
        sdata = $random(seed);
        op    = mem_pkg::mem_op_t'(r[3:0] % 4'd9);
        // words 16 to 31 hold the fill pattern
        addr  = {26'd1, r[9:4]};
        case (op)
            mem_pkg::OP_LD_W, mem_pkg::OP_ST_W: addr[1:0] = 2'b00;
            mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU, mem_pkg::OP_ST_H: addr[0] = 1'b0;
            mem_pkg::OP_ALU: addr = $random(seed);
            default: ;
        endcase
        if (op != mem_pkg::OP_ALU && r[14:10] == 5'd0)
            addr[0] = 1'b1;
        issue_op(op, base, addr - base, sdata, r[22:18]);
        if (r[17:15] == 3'd0)
            idle(1);
    endtask

    always @(negedge clk) begin : compare_retire
        exp_t             e;
        pipe_pkg::rf_wr_t got_rf;
        if (resetn && retire_ready && (rf_we || exc_valid)) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("extra retirement at pc %h with nothing outstanding",
                    retire_pc));
            end else begin
                e = exp_q.pop_front();
                got_rf = '{we: rf_we, waddr: rf_waddr, wdata: rf_wdata};
                if (e.is_exc) begin
                    check_flag("exc_valid", exc_valid, 1'b1);
                    check_flag("rf_we", rf_we, 1'b0);
                    check_exc(exc_code, e.code, exc_pc, e.pc, exc_vaddr, e.vaddr);
                    exc_retired++;
                end else begin
                    check_flag("exc_valid", exc_valid, 1'b0);
                    check_rf(got_rf, e.rf);
                    check_pc(retire_pc, e.pc);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
            report_failure($sformatf("timeout after %0d cycles, retirements stopped", cycles));
    end

    initial begin : run_tests
        int drain_wait;
        resetn        = 1'b0;
        in_valid      = 1'b0;
        in_op         = mem_pkg::OP_ALU;
        in_pc         = '0;
        in_base       = '0;
        in_offset     = '0;
        in_store_data = '0;
        in_rd         = '0;
        retire_ready  = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag("in_allowin", in_allowin, 1'b1);
            check_flag("rf_we", rf_we, 1'b0);
            check_flag("exc_valid", exc_valid, 1'b0);
            next_cycle();
        end

        for (int i = 16; i < 16 + N_FILL; i++)
            issue_op(mem_pkg::OP_ST_W, 32'h0, 32'(i) << 2, fill_word(8'(i)), 5'd0);

        // one store of each width, then every load kind over them
        issue_op(mem_pkg::OP_ST_W, 32'h80, 32'h0, 32'h80f1_7f82, 5'd0);
        issue_op(mem_pkg::OP_ST_H, 32'h84, 32'h0, 32'h0000_8001, 5'd0);
        issue_op(mem_pkg::OP_ST_H, 32'h84, 32'h2, 32'h0000_7ffe, 5'd0);
        issue_op(mem_pkg::OP_ST_B, 32'h88, 32'h0, 32'h0000_0080, 5'd0);
        issue_op(mem_pkg::OP_ST_B, 32'h88, 32'h1, 32'h0000_007f, 5'd0);
        issue_op(mem_pkg::OP_ST_B, 32'h88, 32'h2, 32'h0000_00ff, 5'd0);
        issue_op(mem_pkg::OP_ST_B, 32'h88, 32'h3, 32'h0000_0001, 5'd0);
        issue_op(mem_pkg::OP_LD_W, 32'h80, 32'h0, 32'h0, 5'd1);
        issue_op(mem_pkg::OP_LD_H, 32'h80, 32'h0, 32'h0, 5'd2);
        issue_op(mem_pkg::OP_LD_H, 32'h80, 32'h2, 32'h0, 5'd3);
        issue_op(mem_pkg::OP_LD_HU, 32'h80, 32'h2, 32'h0, 5'd4);
        issue_op(mem_pkg::OP_LD_B, 32'h80, 32'h3, 32'h0, 5'd5);
        issue_op(mem_pkg::OP_LD_BU, 32'h80, 32'h3, 32'h0, 5'd6);
        issue_op(mem_pkg::OP_LD_B, 32'h88, 32'h1, 32'h0, 5'd7);
        issue_op(mem_pkg::OP_LD_B, 32'h88, 32'h2, 32'h0, 5'd8);
        issue_op(mem_pkg::OP_LD_BU, 32'h88, 32'h2, 32'h0, 5'd9);
        issue_op(mem_pkg::OP_LD_H, 32'h84, 32'h0, 32'h0, 5'd10);
        issue_op(mem_pkg::OP_LD_HU, 32'h84, 32'h2, 32'h0, 5'd11);
        issue_op(mem_pkg::OP_LD_W, 32'h88, 32'h0, 32'h0, 5'd12);
        issue_op(mem_pkg::OP_ALU, 32'hffff_fff0, 32'h24, 32'h0, 5'd13);
        issue_op(mem_pkg::OP_ALU, 32'h7fff_ffff, 32'h1, 32'h0, 5'd14);

        // misaligned load and store with younger ops right behind
        issue_op(mem_pkg::OP_ST_W, 32'ha0, 32'h0, 32'h1357_9bdf, 5'd0);
        issue_op(mem_pkg::OP_ST_W, 32'ha4, 32'h0, 32'h2468_ace0, 5'd0);
        issue_op(mem_pkg::OP_LD_W, 32'ha0, 32'h2, 32'h0, 5'd3);
        issue_op(mem_pkg::OP_ST_W, 32'ha0, 32'h0, 32'hffff_0000, 5'd0);
        issue_op(mem_pkg::OP_ST_B, 32'ha4, 32'h1, 32'h0000_0055, 5'd0);
        issue_op(mem_pkg::OP_ALU, 32'h10, 32'h20, 32'h0, 5'd4);
        issue_op(mem_pkg::OP_LD_W, 32'ha0, 32'h0, 32'h0, 5'd5);
        issue_op(mem_pkg::OP_ST_H, 32'ha4, 32'h3, 32'h0000_7777, 5'd0);
        issue_op(mem_pkg::OP_ST_W, 32'ha4, 32'h0, 32'h0, 5'd0);
        issue_op(mem_pkg::OP_ST_H, 32'ha0, 32'h2, 32'h0000_1111, 5'd0);
        idle(4);
        issue_op(mem_pkg::OP_LD_W, 32'ha0, 32'h0, 32'h0, 5'd6);
        issue_op(mem_pkg::OP_LD_W, 32'ha4, 32'h0, 32'h0, 5'd7);
        issue_op(mem_pkg::OP_LD_HU, 32'ha4, 32'h2, 32'h0, 5'd8);

        repeat (N_RAND) issue_random();
        rr_random = 1'b1;
        repeat (N_RAND) issue_random();
        rr_random = 1'b0;

        idle(1);
        drain_wait = 0;
        while (exp_q.size() != 0 && drain_wait < 50) begin
            next_cycle();
            drain_wait++;
        end
        // late extra retirements still show up here
        idle(8);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected retirements never arrived", exp_q.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

//--- logic/mem_pipe_top.sv
`include "pipe_config.svh"

module mem_pipe_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  mem_pkg::mem_op_t      in_op,
    input  logic [`PIPE_XLEN-1:0] in_pc,
    input  logic [`PIPE_XLEN-1:0] in_base,
    input  logic [`PIPE_XLEN-1:0] in_offset,
    input  logic [`PIPE_XLEN-1:0] in_store_data,
    input  logic [4:0]            in_rd,
    input  logic                  retire_ready,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [`PIPE_XLEN-1:0] rf_wdata,
    output logic [`PIPE_XLEN-1:0] retire_pc,
    output logic                  exc_valid,
    output pipe_pkg::exc_code_t   exc_code,
    output logic [`PIPE_XLEN-1:0] exc_pc,
    output logic [`PIPE_XLEN-1:0] exc_vaddr
);
    logic                     sram_en;
    logic [3:0]               sram_we;
    logic [`PIPE_SRAM_AW-1:0] sram_addr;
    logic [`PIPE_XLEN-1:0]    sram_wdata;
    logic [`PIPE_XLEN-1:0]    sram_rdata;

    ex_mem_if ex_mem_bus ();
    mem_wb_if mem_wb_bus ();

    ex_stage ex_stage_i (
        .clk           (clk),
        .resetn        (resetn),
        .in_valid      (in_valid),
        .in_allowin    (in_allowin),
        .in_op         (in_op),
        .in_pc         (in_pc),
        .in_base       (in_base),
        .in_offset     (in_offset),
        .in_store_data (in_store_data),
        .in_rd         (in_rd),
        .sram_en       (sram_en),
        .sram_we       (sram_we),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata),
        .ex_mem        (ex_mem_bus),
        .flush         (mem_wb_bus.flush)
    );

    mem_stage mem_stage_i (
        .clk        (clk),
        .resetn     (resetn),
        .ex_mem     (ex_mem_bus),
        .mem_wb     (mem_wb_bus),
        .sram_rdata (sram_rdata)
    );

    wb_stage wb_stage_i (
        .clk          (clk),
        .resetn       (resetn),
        .mem_wb       (mem_wb_bus),
        .retire_ready (retire_ready),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_pc    (retire_pc),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_pc       (exc_pc),
        .exc_vaddr    (exc_vaddr)
    );

    data_sram data_sram_i (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

//--- logic/data_sram.sv
`include "pipe_config.svh"

module data_sram (
    input  logic                     clk,
    input  logic                     en,
    input  logic [3:0]               we,
    input  logic [`PIPE_SRAM_AW-1:0] addr,
    input  logic [`PIPE_XLEN-1:0]    wdata,
    output logic [`PIPE_XLEN-1:0]    rdata
);
    logic [`PIPE_XLEN-1:0] mem [`PIPE_SRAM_DEPTH];

    // read returns the old word on a write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

//--- logic/wb_stage.sv
`include "pipe_config.svh"

module wb_stage (
    input  logic                  clk,
    input  logic                  resetn,
    mem_wb_if.wb                  mem_wb,
    input  logic                  retire_ready,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [`PIPE_XLEN-1:0] rf_wdata,
    output logic [`PIPE_XLEN-1:0] retire_pc,
    output logic                  exc_valid,
    output pipe_pkg::exc_code_t   exc_code,
    output logic [`PIPE_XLEN-1:0] exc_pc,
    output logic [`PIPE_XLEN-1:0] exc_vaddr
);
    logic                  ws_valid;
    logic                  ws_ready_go;
    logic                  ws_allowin;
    logic [`PIPE_XLEN-1:0] ws_pc;
    logic [`PIPE_XLEN-1:0] ws_vaddr;
    pipe_pkg::exc_code_t   ws_except;
    pipe_pkg::rf_wr_t      ws_rf;
    logic                  has_exc;

    assign ws_ready_go = retire_ready;
    assign ws_allowin  = ~ws_valid | ws_ready_go;

    // younger op in mem is dropped while an exception sits here
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= mem_wb.valid & ~has_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb.valid && ws_allowin) begin
            ws_pc     <= mem_wb.pc;
            ws_vaddr  <= mem_wb.vaddr;
            ws_except <= mem_wb.except;
            ws_rf     <= mem_wb.rf;
        end
    end

    assign has_exc = ws_valid & (ws_except != pipe_pkg::EXC_NONE);

    assign mem_wb.allowin = ws_allowin;
    assign mem_wb.flush   = has_exc;

    assign rf_we     = ws_valid & ws_rf.we;
    assign rf_waddr  = ws_rf.waddr;
    assign rf_wdata  = ws_rf.wdata;
    assign retire_pc = ws_pc;

    assign exc_valid = has_exc;
    assign exc_code  = ws_except;
    assign exc_pc    = ws_pc;
    assign exc_vaddr = ws_vaddr;

endmodule

//--- logic/mem_stage.sv
`include "pipe_config.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  resetn,
    ex_mem_if.mem                 ex_mem,
    mem_wb_if.mem                 mem_wb,
    input  logic [`PIPE_XLEN-1:0] sram_rdata
);
    logic                  ms_valid;
    logic                  ms_ready_go;
    logic                  ms_allowin;
    logic [`PIPE_XLEN-1:0] ms_pc;
    mem_pkg::mem_op_t      ms_op;
    logic [4:0]            ms_rd;
    logic                  ms_rf_we;
    logic                  ms_res_from_mem;
    logic [`PIPE_XLEN-1:0] ms_alu_result;
    pipe_pkg::exc_code_t   ms_except;
    mem_pkg::rdata_u       rd_word;
    logic [15:0]           half_sel;
    logic [7:0]            byte_sel;
    logic                  sign_ext;
    logic [`PIPE_XLEN-1:0] mem_result;

    // loads never wait, sram data lands in this cycle
    assign ms_ready_go = 1'b1;
    assign ms_allowin  = ~ms_valid | ms_ready_go & mem_wb.allowin;

    always_ff @(posedge clk) begin
        if (!resetn || mem_wb.flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ms_allowin) begin
            ms_pc           <= ex_mem.pc;
            ms_op           <= ex_mem.op;
            ms_rd           <= ex_mem.rd;
            ms_rf_we        <= ex_mem.rf_we;
            ms_res_from_mem <= ex_mem.res_from_mem;
            ms_alu_result   <= ex_mem.alu_result;
            ms_except       <= ex_mem.except;
        end
    end

    assign rd_word  = sram_rdata;
    assign half_sel = rd_word.halves[ms_alu_result[1]];
    assign byte_sel = rd_word.bytes[ms_alu_result[1:0]];
    assign sign_ext = ms_op == mem_pkg::OP_LD_H || ms_op == mem_pkg::OP_LD_B;

    always_comb begin
        case (ms_op)
            mem_pkg::OP_LD_W:
                mem_result = rd_word;
            mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU:
                mem_result = {{16{sign_ext & half_sel[15]}}, half_sel};
            mem_pkg::OP_LD_B, mem_pkg::OP_LD_BU:
                mem_result = {{24{sign_ext & byte_sel[7]}}, byte_sel};
            default:
                mem_result = '0;
        endcase
    end

    assign ex_mem.allowin        = ms_allowin;
    assign ex_mem.except_pending = ms_valid & (ms_except != pipe_pkg::EXC_NONE);

    assign mem_wb.valid  = ms_valid & ms_ready_go;
    assign mem_wb.pc     = ms_pc;
    assign mem_wb.vaddr  = ms_alu_result;
    assign mem_wb.except = ms_except;
    assign mem_wb.rf     = '{
        we:    ms_rf_we & ms_valid,
        waddr: ms_rd,
        wdata: ms_res_from_mem ? mem_result : ms_alu_result
    };

endmodule

//--- logic/ex_stage.sv
`include "pipe_config.svh"

module ex_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  mem_pkg::mem_op_t         in_op,
    input  logic [`PIPE_XLEN-1:0]    in_pc,
    input  logic [`PIPE_XLEN-1:0]    in_base,
    input  logic [`PIPE_XLEN-1:0]    in_offset,
    input  logic [`PIPE_XLEN-1:0]    in_store_data,
    input  logic [4:0]               in_rd,
    output logic                     sram_en,
    output logic [3:0]               sram_we,
    output logic [`PIPE_SRAM_AW-1:0] sram_addr,
    output logic [`PIPE_XLEN-1:0]    sram_wdata,
    ex_mem_if.ex                     ex_mem,
    input  logic                     flush
);
    logic                  es_valid;
    logic                  es_allowin;
    mem_pkg::mem_op_t      es_op;
    logic [`PIPE_XLEN-1:0] es_pc;
    logic [`PIPE_XLEN-1:0] es_base;
    logic [`PIPE_XLEN-1:0] es_offset;
    logic [`PIPE_XLEN-1:0] es_store_data;
    logic [4:0]            es_rd;
    logic [`PIPE_XLEN-1:0] es_addr;
    logic                  is_load;
    logic                  is_store;
    logic                  misaligned;
    logic                  access_ok;
    logic [3:0]            st_mask;
    logic [`PIPE_XLEN-1:0] st_wdata;

    assign es_allowin  = ~es_valid | ex_mem.allowin;
    // nothing new enters while wb is flushing
    assign in_allowin  = es_allowin & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_op         <= in_op;
            es_pc         <= in_pc;
            es_base       <= in_base;
            es_offset     <= in_offset;
            es_store_data <= in_store_data;
            es_rd         <= in_rd;
        end
    end

    assign es_addr  = es_base + es_offset;
    assign is_load  = es_op inside {mem_pkg::OP_LD_W, mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU,
                                    mem_pkg::OP_LD_B, mem_pkg::OP_LD_BU};
    assign is_store = es_op inside {mem_pkg::OP_ST_W, mem_pkg::OP_ST_H, mem_pkg::OP_ST_B};

    always_comb begin
        case (es_op)
            mem_pkg::OP_LD_W, mem_pkg::OP_ST_W:
                misaligned = es_addr[1:0] != 2'b00;
            mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU, mem_pkg::OP_ST_H:
                misaligned = es_addr[0];
            default:
                misaligned = 1'b0;
        endcase
    end

    // replicate store data into every lane, mask picks the live one
    always_comb begin
        st_mask  = 4'b0000;
        st_wdata = es_store_data;
        case (es_op)
            mem_pkg::OP_ST_W: st_mask = 4'b1111;
            mem_pkg::OP_ST_H: begin
                st_mask  = es_addr[1] ? 4'b1100 : 4'b0011;
                st_wdata = {2{es_store_data[15:0]}};
            end
            mem_pkg::OP_ST_B: begin
                st_mask  = 4'b0001 << es_addr[1:0];
                st_wdata = {4{es_store_data[7:0]}};
            end
            default: ;
        endcase
    end

    // access only on the move into mem, never behind an exception
    assign access_ok  = es_valid & ex_mem.allowin & ~misaligned & ~flush & ~ex_mem.except_pending;
    assign sram_en    = access_ok & (is_load | is_store);
    assign sram_we    = {4{access_ok & is_store}} & st_mask;
    assign sram_addr  = es_addr[`PIPE_SRAM_AW+1:2];
    assign sram_wdata = st_wdata;

    assign ex_mem.valid        = es_valid;
    assign ex_mem.pc           = es_pc;
    assign ex_mem.op           = es_op;
    assign ex_mem.rd           = es_rd;
    assign ex_mem.rf_we        = ~is_store & ~misaligned;
    assign ex_mem.res_from_mem = is_load;
    assign ex_mem.alu_result   = es_addr;
    assign ex_mem.except       = misaligned ? pipe_pkg::EXC_ALE : pipe_pkg::EXC_NONE;

endmodule

//--- logic/stage_if.sv
`include "pipe_config.svh"

// execute to memory stage bus
interface ex_mem_if;
    logic                  valid;
    logic                  allowin;
    logic [`PIPE_XLEN-1:0] pc;
    mem_pkg::mem_op_t      op;
    logic [4:0]            rd;
    logic                  rf_we;
    logic                  res_from_mem;
    // doubles as the access address
    logic [`PIPE_XLEN-1:0] alu_result;
    pipe_pkg::exc_code_t   except;
    logic                  except_pending;

    modport ex (
        output valid, pc, op, rd, rf_we, res_from_mem, alu_result, except,
        input  allowin, except_pending
    );

    modport mem (
        input  valid, pc, op, rd, rf_we, res_from_mem, alu_result, except,
        output allowin, except_pending
    );
endinterface

// memory to writeback stage bus
interface mem_wb_if;
    logic                  valid;
    logic                  allowin;
    logic [`PIPE_XLEN-1:0] pc;
    logic [`PIPE_XLEN-1:0] vaddr;
    pipe_pkg::exc_code_t   except;
    pipe_pkg::rf_wr_t      rf;
    logic                  flush;

    modport mem (
        output valid, pc, vaddr, except, rf,
        input  allowin, flush
    );

    modport wb (
        input  valid, pc, vaddr, except, rf,
        output allowin, flush
    );
endinterface

//--- logic/mem_pkg.sv
package mem_pkg;

    // access kind carried down the pipe
    typedef enum logic [3:0] {
        OP_ALU   = 4'd0,
        OP_LD_W  = 4'd1,
        OP_LD_H  = 4'd2,
        OP_LD_HU = 4'd3,
        OP_LD_B  = 4'd4,
        OP_LD_BU = 4'd5,
        OP_ST_W  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_B  = 4'd8
    } mem_op_t;

    // one sram word, seen as halves or as bytes
    typedef union packed {
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } rdata_u;

endpackage

//--- logic/pipe_pkg.sv
`include "pipe_config.svh"

package pipe_pkg;

    // ecode values follow the loongarch numbering
    typedef enum logic [5:0] {
        EXC_NONE = 6'h00,
        EXC_ALE  = 6'h09
    } exc_code_t;

    // register file write request
    typedef struct packed {
        logic                  we;
        logic [4:0]            waddr;
        logic [`PIPE_XLEN-1:0] wdata;
    } rf_wr_t;

endpackage

//--- logic/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// datapath and address width
`define PIPE_XLEN 32

// data sram is word addressed
`define PIPE_SRAM_AW 8

// word count follows from the address width
`define PIPE_SRAM_DEPTH (1 << `PIPE_SRAM_AW)

`endif
